//--- verilog.f
+incdir+src
src/nocPkg.sv
src/flitFifo.sv
src/lbdr.sv
src/outputArbiter.sv
src/crossbar.sv
src/routerTop.sv
sim/routerChecker.sv
sim/routerTb.sv

//--- run.sh
#!/usr/bin/env bash
# Builds the router testbench with Verilator, runs it and checks the log

cd "$(dirname "$0")" || exit 1

BUILD_LOG=build.log
SIM_LOG=sim.log

rm -rf obj_dir
verilator --binary --timing --top-module routerTb -f verilog.f -o routerSim > "$BUILD_LOG" 2>&1
if [ $? -ne 0 ]; then
  cat "$BUILD_LOG"
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/routerSim > "$SIM_LOG" 2>&1
status=$?
cat "$SIM_LOG"
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -qx "TEST RESULT: PASS" "$SIM_LOG"; then
  exit 0
fi
echo "Pass message not found in $SIM_LOG"
exit 1

//--- sim/routerTb.sv
// Router testbench with clock, reset, configuration, random packets and test sequence
`timescale 1ns/1ps
`include "nocSettings.svh"

module routerTb;

  // Packets per input in each random test and in each burst
  localparam int RandPkts       = 8;
  localparam int BurstPkts      = 4;
  localparam int TotalPkts      = (4 * RandPkts + 2 * BurstPkts) * `NUM_PORTS;
  localparam int WatchdogCycles = TotalPkts * 6 * 20;
  localparam int DrainCycles    = 400;

  localparam nocPkg::routeBits_t XyRoute  = 8'd60;
  localparam nocPkg::routeBits_t YxRoute  = 8'd195;
  localparam nocPkg::connBits_t  AllLinks = 4'b1111;
  // Ce cleared
  localparam nocPkg::connBits_t  NoEast   = 4'b1101;
  localparam nocPkg::addr_t      HereAddr = 4'd5;

  logic               clk;
  logic               rst;
  nocPkg::routeBits_t routeCfg;
  nocPkg::connBits_t  connCfg;
  nocPkg::addr_t      curAddr;
  nocPkg::portVec_t   inValid;
  nocPkg::flit_t      inFlit [`NUM_PORTS];
  nocPkg::portVec_t   inFull;
  nocPkg::portVec_t   outValid;
  nocPkg::flit_t      outFlit [`NUM_PORTS];
  logic [15:0]        dropCount;
  // Flits still to send per input
  nocPkg::flit_t      txQ [`NUM_PORTS][$];
  int                 seed = 32'h21bc8932;
  int                 seqNo = 0;

  routerTop dut_i (
    .clk       (clk),
    .rst       (rst),
    .routeCfg  (routeCfg),
    .connCfg   (connCfg),
    .curAddr   (curAddr),
    .inValid   (inValid),
    .inFlit    (inFlit),
    .inFull    (inFull),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .dropCount (dropCount)
  );

  routerChecker chk_i (
    .clk       (clk),
    .rst       (rst),
    .routeCfg  (routeCfg),
    .connCfg   (connCfg),
    .curAddr   (curAddr),
    .inValid   (inValid),
    .inFlit    (inFlit),
    .inFull    (inFull),
    .outValid  (outValid),
    .outFlit   (outFlit),
    .dropCount (dropCount)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  task automatic endRun(input bit failed);
    if (failed) begin
      $display("TEST RESULT: FAIL");
    end else begin
      $display("TEST RESULT: PASS");
    end
    $finish;
  endtask

  // Configuration is held with reset for eight cycles
  task automatic applyReset(nocPkg::routeBits_t routeBits, nocPkg::connBits_t connBits);
    @(posedge clk);
    rst      <= 1'b1;
    routeCfg <= routeBits;
    connCfg  <= connBits;
    inValid  <= '0;
    repeat (8) @(posedge clk);
    rst <= 1'b0;
  endtask

  // Header carries source port and sequence number
  task automatic queuePacket(int src, nocPkg::addr_t dst);
    int nPay;
    nPay = $unsigned($random(seed)) % 4;
    txQ[src].push_back({`HEADER, dst, 3'(src), 6'd0, 16'(seqNo)});
    for (int k = 0; k < nPay; k++) begin
      txQ[src].push_back({`PAYLOAD, 29'($random(seed))});
    end
    txQ[src].push_back({`TAIL, 29'($random(seed))});
    seqNo++;
  endtask

  task automatic sendQueued();
    logic busy;
    busy = 1'b1;
    while (busy) begin
      @(posedge clk);
      busy = 1'b0;
      for (int i = 0; i < `NUM_PORTS; i++) begin
        if (inValid[i]) begin
          // Idle cycle after each write, so inFull seen now is still valid at the write
          inValid[i] <= 1'b0;
        end else if (txQ[i].size() > 0 && !inFull[i] && (($random(seed) & 3) != 0)) begin
          inFlit[i]  <= txQ[i].pop_front();
          inValid[i] <= 1'b1;
        end
        if (txQ[i].size() > 0) begin
          busy = 1'b1;
        end
      end
    end
    @(posedge clk);
    inValid <= '0;
  endtask

  // Checker says when every expected flit and drop is seen
  task automatic waitDrain();
    int cycles;
    cycles = 0;
    while (!chk_i.drained() && cycles < DrainCycles) begin
      @(posedge clk);
      cycles++;
    end
  endtask

  task automatic trafficTest(string name, nocPkg::routeBits_t routeBits,
                             nocPkg::connBits_t connBits, int pkts, bit toLocal);
    chk_i.startTest(name);
    applyReset(routeBits, connBits);
    for (int n = 0; n < pkts; n++) begin
      for (int i = 0; i < `NUM_PORTS; i++) begin
        // Burst mode aims every packet at this router
        queuePacket(i, toLocal ? HereAddr : nocPkg::addr_t'($random(seed)));
      end
    end
    sendQueued();
    waitDrain();
    chk_i.endTest();
  endtask

  initial begin
    rst      = 1'b1;
    routeCfg = XyRoute;
    connCfg  = AllLinks;
    curAddr  = HereAddr;
    inValid  = '0;
    for (int i = 0; i < `NUM_PORTS; i++) begin
      inFlit[i] = '0;
    end
    // Quiet outputs during and after a reset that cuts into a contended burst
    chk_i.startTest("resetState");
    applyReset(XyRoute, AllLinks);
    for (int n = 0; n < BurstPkts; n++) begin
      for (int i = 0; i < `NUM_PORTS; i++) begin
        queuePacket(i, HereAddr);
      end
    end
    sendQueued();
    applyReset(XyRoute, AllLinks);
    repeat (3) begin
      @(negedge clk);
      chk_i.checkIdle();
    end
    chk_i.endTest();
    trafficTest("xyRouting", XyRoute, AllLinks, RandPkts, 1'b0);
    trafficTest("packetIntegrity", XyRoute, AllLinks, RandPkts, 1'b0);
    trafficTest("yxRouting", YxRoute, AllLinks, RandPkts, 1'b0);
    trafficTest("eastDisconnected", XyRoute, NoEast, RandPkts, 1'b0);
    trafficTest("localContention", XyRoute, AllLinks, BurstPkts, 1'b1);
    chk_i.printCounts();
    endRun(chk_i.totalErrors != 0 || chk_i.testsFailed != 0);
  end

  // Watchdog
  initial begin
    repeat (WatchdogCycles) @(posedge clk);
    $display("Watchdog expired after %0d cycles, traffic never finished", WatchdogCycles);
    endRun(1'b1);
  end

endmodule

//--- sim/routerChecker.sv
// Router checker with an LBDR reference model, expected flit queues and result reporting
`timescale 1ns/1ps
`include "nocSettings.svh"

module routerChecker (
  input  logic               clk,
  input  logic               rst,
  input  nocPkg::routeBits_t routeCfg,
  input  nocPkg::connBits_t  connCfg,
  input  nocPkg::addr_t      curAddr,
  input  nocPkg::portVec_t   inValid,
  input  nocPkg::flit_t      inFlit [`NUM_PORTS],
  input  nocPkg::portVec_t   inFull,
  input  nocPkg::portVec_t   outValid,
  input  nocPkg::flit_t      outFlit [`NUM_PORTS],
  input  logic [15:0]        dropCount
);

  nocPkg::routeBits_t routeReg;
  nocPkg::connBits_t  connReg;
  nocPkg::addr_t      addrReg;
  // Expected flits per queue index src * 5 + out
  nocPkg::flit_t      expQ [`NUM_PORTS * `NUM_PORTS][$];
  // Model route per input where -1 means drained
  int                 route [`NUM_PORTS];
  // Source of the packet in flight per output
  int                 pktSrc [`NUM_PORTS];
  int                 pending = 0;
  int                 modelDrops = 0;
  int                 testErrors = 0;
  int                 totalErrors = 0;
  int                 testsRun = 0;
  int                 testsFailed = 0;
  string              curTest = "none";
  // Reset already seen at the previous falling edge, so the router has taken it
  logic               rstTaken = 1'b0;

  // First hop of a header under minimal LBDR or -1 when no link is usable
  function automatic int lbdrPort(nocPkg::addr_t dst);
    logic n;
    logic s;
    logic e;
    logic w;
    int   vPort;
    int   hPort;
    int   vIdx;
    int   hIdx;
    n = dst[3:2] < addrReg[3:2];
    s = dst[3:2] > addrReg[3:2];
    e = dst[1:0] > addrReg[1:0];
    w = dst[1:0] < addrReg[1:0];
    vPort = n ? `PORT_N : `PORT_S;
    hPort = e ? `PORT_E : `PORT_W;
    // Routing bit positions for the quadrant
    vIdx = (n ? 0 : 6) + (e ? 0 : 1);
    hIdx = (e ? 2 : 4) + (n ? 0 : 1);
    if (!(n | s) && !(e | w)) begin
      return `PORT_L;
    end
    if (!(e | w)) begin
      return connReg[vPort] ? vPort : -1;
    end
    if (!(n | s)) begin
      return connReg[hPort] ? hPort : -1;
    end
    // Diagonal goes vertical first if its bit allows
    if (routeReg[vIdx] && connReg[vPort]) begin
      return vPort;
    end
    if (routeReg[hIdx] && connReg[hPort]) begin
      return hPort;
    end
    return -1;
  endfunction

  task automatic failure(string msg);
    $display("%s: %s", curTest, msg);
    testErrors++;
    totalErrors++;
  endtask

  task automatic valueCheck(string what, logic [31:0] expVal, logic [31:0] actVal);
    if (expVal !== actVal) begin
      $display("Error: %s: %s expected %h actual %h", curTest, what, expVal, actVal);
      testErrors++;
      totalErrors++;
    end
  endtask

  task automatic startTest(string name);
    curTest    = name;
    testErrors = 0;
  endtask

  task automatic endTest();
    if (pending != 0) begin
      failure($sformatf("%0d flits never left the router", pending));
    end
    valueCheck("dropCount", 32'(modelDrops), 32'(dropCount));
    testsRun++;
    if (testErrors != 0) begin
      testsFailed++;
    end
    $display("Test %s: %s, %0d errors", curTest, (testErrors == 0) ? "passed" : "failed",
             testErrors);
  endtask

  // Idle router right after reset
  task automatic checkIdle();
    valueCheck("inFull", 32'(0), 32'(inFull));
    valueCheck("outValid", 32'(0), 32'(outValid));
  endtask

  function automatic bit drained();
    return (pending == 0) && (32'(dropCount) == 32'(modelDrops));
  endfunction

  task automatic printCounts();
    $display("Tests run %0d, failed %0d, errors %0d", testsRun, testsFailed, totalErrors);
  endtask

  // Inputs and outputs are stable at the falling edge
  always @(negedge clk) begin
    nocPkg::flit_t   f;
    nocPkg::flitId_t id;
    int              q;
    if (rst) begin
      // Same sampling of the configuration as the router
      routeReg   = routeCfg;
      connReg    = connCfg;
      addrReg    = curAddr;
      pending    = 0;
      modelDrops = 0;
      for (int k = 0; k < `NUM_PORTS; k++) begin
        route[k]  = -1;
        pktSrc[k] = -1;
      end
      for (int k = 0; k < `NUM_PORTS * `NUM_PORTS; k++) begin
        expQ[k].delete();
      end
      // Outputs are quiet from the first edge that sees reset
      if (rstTaken && (|outValid) !== 1'b0) begin
        failure("outValid strobe during reset");
      end
      rstTaken = 1'b1;
    end else begin
      rstTaken = 1'b0;
      // Accepted writes feed the model
      for (int i = 0; i < `NUM_PORTS; i++) begin
        if (inValid[i] && !inFull[i]) begin
          f = inFlit[i];
          if (f[`ID_HI:`ID_LO] == `HEADER) begin
            route[i] = lbdrPort(f[`DST_HI:`DST_LO]);
            if (route[i] < 0) begin
              modelDrops++;
            end
          end
          if (route[i] >= 0) begin
            expQ[i * `NUM_PORTS + route[i]].push_back(f);
            pending++;
          end
        end
      end
      // Output strobes against the expected queues
      for (int j = 0; j < `NUM_PORTS; j++) begin
        if (outValid[j]) begin
          f  = outFlit[j];
          id = f[`ID_HI:`ID_LO];
          if (id == `HEADER) begin
            if (pktSrc[j] >= 0) begin
              failure($sformatf("header on port %0d interleaved into a packet", j));
            end
            // Source port rides in the header
            pktSrc[j] = (int'(f[24:22]) < `NUM_PORTS) ? int'(f[24:22]) : -1;
          end
          if (pktSrc[j] < 0) begin
            failure($sformatf("flit %h on port %0d belongs to no known packet", f, j));
          end else begin
            q = pktSrc[j] * `NUM_PORTS + j;
            if (expQ[q].size() == 0) begin
              failure($sformatf("flit %h left on port %0d, which it was not routed to", f, j));
            end else begin
              pending--;
              valueCheck($sformatf("port %0d flit", j), expQ[q].pop_front(), f);
            end
            if (id == `TAIL) begin
              pktSrc[j] = -1;
            end
          end
        end
      end
    end
  end

endmodule

//--- src/routerTop.sv
// Five-port mesh router top with input FIFOs, LBDR, output arbiters and crossbar
`timescale 1ns/1ps
`include "nocSettings.svh"

module routerTop (
  input  logic               clk,
  input  logic               rst,
  input  nocPkg::routeBits_t routeCfg,
  input  nocPkg::connBits_t  connCfg,
  input  nocPkg::addr_t      curAddr,
  input  nocPkg::portVec_t   inValid,
  input  nocPkg::flit_t      inFlit [`NUM_PORTS],
  output nocPkg::portVec_t   inFull,
  output nocPkg::portVec_t   outValid,
  output nocPkg::flit_t      outFlit [`NUM_PORTS],
  output logic [15:0]        dropCount
);

  nocPkg::flit_t    heads [`NUM_PORTS];
  nocPkg::portVec_t portSel [`NUM_PORTS];
  nocPkg::portVec_t req [`NUM_PORTS];
  nocPkg::portVec_t grant [`NUM_PORTS];
  nocPkg::portVec_t grantEff [`NUM_PORTS];
  nocPkg::portVec_t emptyVec;
  nocPkg::portVec_t noRouteVec;
  nocPkg::portVec_t hdrAtHead;
  nocPkg::portVec_t tailAtHead;
  nocPkg::portVec_t hdrRouted;
  nocPkg::portVec_t routeReady;
  nocPkg::portVec_t grantPop;
  nocPkg::portVec_t dropPop;
  nocPkg::portVec_t pop;

  // Input units
  for (genvar i = 0; i < `NUM_PORTS; i++) begin : gInput
    flitFifo fifo_i (
      .clk    (clk),
      .rst    (rst),
      .wrEn   (inValid[i]),
      .wrFlit (inFlit[i]),
      .rdEn   (pop[i]),
      .head   (heads[i]),
      .empty  (emptyVec[i]),
      .full   (inFull[i])
    );

    lbdr lbdr_i (
      .clk        (clk),
      .rst        (rst),
      .routeCfg   (routeCfg),
      .connCfg    (connCfg),
      .curAddrCfg (curAddr),
      .empty      (emptyVec[i]),
      .head       (heads[i]),
      .portSel    (portSel[i]),
      .noRoute    (noRouteVec[i])
    );

    // Flit type at a non-empty head
    assign hdrAtHead[i]  = ~emptyVec[i] & (heads[i][`ID_HI:`ID_LO] == `HEADER);
    assign tailAtHead[i] = ~emptyVec[i] & (heads[i][`ID_HI:`ID_LO] == `TAIL);
  end

  // A fresh header waits one cycle for its own route
  assign routeReady = ~emptyVec & (~hdrAtHead | hdrRouted);

  always_ff @(posedge clk) begin
    if (rst) begin
      hdrRouted <= '0;
    end else begin
      hdrRouted <= hdrAtHead & ~pop;
    end
  end

  // Requests, transposed from per-input route to per-output vector
  always_comb begin
    for (int j = 0; j < `NUM_PORTS; j++) begin
      for (int i = 0; i < `NUM_PORTS; i++) begin
        req[j][i] = portSel[i][j] & routeReady[i];
      end
      // Only move flits that are present
      grantEff[j] = grant[j] & ~emptyVec;
    end
  end

  // Output arbiters
  for (genvar j = 0; j < `NUM_PORTS; j++) begin : gOutput
    outputArbiter arb_i (
      .clk        (clk),
      .rst        (rst),
      .req        (req[j]),
      .tailAtHead (tailAtHead),
      .grant      (grant[j])
    );
  end

  // Pop from any granting output, or drain an unroutable packet
  always_comb begin
    grantPop = '0;
    for (int j = 0; j < `NUM_PORTS; j++) begin
      grantPop = grantPop | grantEff[j];
    end
    dropPop = noRouteVec & routeReady;
    pop     = grantPop | dropPop;
  end

  crossbar xbar_i (
    .clk      (clk),
    .rst      (rst),
    .heads    (heads),
    .grants   (grantEff),
    .outValid (outValid),
    .outFlit  (outFlit)
  );

  // One drop per discarded header, several inputs may drop together
  always_ff @(posedge clk) begin
    if (rst) begin
      dropCount <= '0;
    end else begin
      dropCount <= dropCount + 16'($countones(dropPop & hdrAtHead));
    end
  end

endmodule

//--- src/crossbar.sv
// 5x5 flit crossbar with registered outputs, selected by one-hot grants
`timescale 1ns/1ps
`include "nocSettings.svh"

module crossbar (
  input  logic             clk,
  input  logic             rst,
  input  nocPkg::flit_t    heads [`NUM_PORTS],
  input  nocPkg::portVec_t grants [`NUM_PORTS],
  output nocPkg::portVec_t outValid,
  output nocPkg::flit_t    outFlit [`NUM_PORTS]
);

  nocPkg::flit_t muxFlit [`NUM_PORTS];

  // AND-OR mux per output, grants are one-hot
  always_comb begin
    for (int j = 0; j < `NUM_PORTS; j++) begin
      muxFlit[j] = '0;
      for (int i = 0; i < `NUM_PORTS; i++) begin
        muxFlit[j] = muxFlit[j] | (heads[i] & {`FLIT_W{grants[j][i]}});
      end
    end
  end

  // Strobe per output
  always_ff @(posedge clk) begin
    if (rst) begin
      outValid <= '0;
    end else begin
      for (int j = 0; j < `NUM_PORTS; j++) begin
        outValid[j] <= |grants[j];
      end
    end
  end

  // Flit register
  always_ff @(posedge clk) begin
    for (int j = 0; j < `NUM_PORTS; j++) begin
      outFlit[j] <= muxFlit[j];
    end
  end

endmodule

//--- src/outputArbiter.sv
// Round-robin output arbiter, grant locked from header to tail
`timescale 1ns/1ps
`include "nocSettings.svh"

module outputArbiter (
  input  logic             clk,
  input  logic             rst,
  input  nocPkg::portVec_t req,
  input  nocPkg::portVec_t tailAtHead,
  output nocPkg::portVec_t grant
);

  localparam int IdxW = $clog2(`NUM_PORTS);

  nocPkg::arbState_t state;
  logic [IdxW-1:0]   lastWin;
  logic [IdxW-1:0]   pickIdx;
  nocPkg::portVec_t  pick;
  logic              found;
  logic              tailPop;

  // Search starts one past the last winner
  always_comb begin
    int idx;
    pick    = '0;
    found   = 1'b0;
    pickIdx = lastWin;
    for (int k = 1; k <= `NUM_PORTS; k++) begin
      idx = (int'(lastWin) + k) % `NUM_PORTS;
      if (!found && req[idx]) begin
        found        = 1'b1;
        pick[idx]    = 1'b1;
        pickIdx      = IdxW'(idx);
      end
    end
  end

  // Granted input pops its tail this cycle
  assign tailPop = |(grant & tailAtHead);

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= nocPkg::arbIdle;
      grant   <= '0;
      // Input 0 has first priority out of reset
      lastWin <= IdxW'(`NUM_PORTS - 1);
    end else begin
      case (state)
        nocPkg::arbIdle: begin
          if (found) begin
            grant   <= pick;
            lastWin <= pickIdx;
            state   <= nocPkg::arbLocked;
          end
        end
        nocPkg::arbLocked: begin
          // Free one cycle after the tail leaves
          if (tailPop) begin
            grant <= '0;
            state <= nocPkg::arbIdle;
          end
        end
        default: begin
          grant <= '0;
          state <= nocPkg::arbIdle;
        end
      endcase
    end
  end

endmodule

//--- src/lbdr.sv
// LBDR route computation on header flits, minimal paths with latched configuration
`timescale 1ns/1ps
`include "nocSettings.svh"

module lbdr (
  input  logic               clk,
  input  logic               rst,
  input  nocPkg::routeBits_t routeCfg,
  input  nocPkg::connBits_t  connCfg,
  input  nocPkg::addr_t      curAddrCfg,
  input  logic               empty,
  input  nocPkg::flit_t      head,
  output nocPkg::portVec_t   portSel,
  output logic               noRoute
);

  nocPkg::routeBits_t routeReg;
  nocPkg::connBits_t  connReg;
  nocPkg::addr_t      curAddr;
  nocPkg::addr_t      dstAddr;
  nocPkg::flitId_t    flitId;
  nocPkg::portVec_t   nextSel;
  logic               isHeader;
  logic               goN;
  logic               goE;
  logic               goW;
  logic               goS;

  // Configuration is sampled only while reset is held
  always_ff @(posedge clk) begin
    if (rst) begin
      routeReg <= routeCfg;
      connReg  <= connCfg;
      curAddr  <= curAddrCfg;
    end
  end

  assign flitId   = head[`ID_HI:`ID_LO];
  assign dstAddr  = head[`DST_HI:`DST_LO];
  assign isHeader = ~empty & (flitId == `HEADER);

  // Direction comparators, y grows southward
  assign goN = dstAddr[3:2] < curAddr[3:2];
  assign goS = curAddr[3:2] < dstAddr[3:2];
  assign goE = curAddr[1:0] < dstAddr[1:0];
  assign goW = dstAddr[1:0] < curAddr[1:0];

  // Minimal LBDR equations
  always_comb begin
    nextSel = '0;
    // Rne, Rnw
    nextSel[`PORT_N] = ((goN & ~goE & ~goW) | (goN & goE & routeReg[0])
                       | (goN & goW & routeReg[1])) & connReg[0];
    // Ren, Res
    nextSel[`PORT_E] = ((goE & ~goN & ~goS) | (goE & goN & routeReg[2])
                       | (goE & goS & routeReg[3])) & connReg[1];
    // Rwn needs north here, Rws south
    nextSel[`PORT_W] = ((goW & ~goN & ~goS) | (goW & goN & routeReg[4])
                       | (goW & goS & routeReg[5])) & connReg[2];
    // Rse, Rsw
    nextSel[`PORT_S] = ((goS & ~goE & ~goW) | (goS & goE & routeReg[6])
                       | (goS & goW & routeReg[7])) & connReg[3];
    // Arrived, deliver locally
    nextSel[`PORT_L] = ~goN & ~goE & ~goW & ~goS;
  end

  // Route held from header until the next header, empty does not clear it
  always_ff @(posedge clk) begin
    if (rst) begin
      portSel <= '0;
      noRoute <= 1'b0;
    end else if (isHeader) begin
      portSel <= nextSel;
      // Needed link is disconnected
      noRoute <= ~|nextSel;
    end
  end

endmodule

//--- src/flitFifo.sv
// Flit FIFO for one input port, show-ahead head with full and empty levels
`timescale 1ns/1ps
`include "nocSettings.svh"

module flitFifo (
  input  logic          clk,
  input  logic          rst,
  input  logic          wrEn,
  input  nocPkg::flit_t wrFlit,
  input  logic          rdEn,
  output nocPkg::flit_t head,
  output logic          empty,
  output logic          full
);

  localparam int PtrW = $clog2(`FIFO_DEPTH);
  localparam int CntW = $clog2(`FIFO_DEPTH + 1);

  nocPkg::flit_t   mem [`FIFO_DEPTH];
  logic [PtrW-1:0] wrPtr;
  logic [PtrW-1:0] rdPtr;
  logic [CntW-1:0] count;
  logic            doWrite;
  logic            doRead;

  // A write while full is dropped, a read while empty does nothing
  assign doWrite = wrEn & ~full;
  assign doRead  = rdEn & ~empty;

  assign empty = (count == '0);
  assign full  = (count == CntW'(`FIFO_DEPTH));

  // Show-ahead output
  assign head = mem[rdPtr];

  // Storage
  always_ff @(posedge clk) begin
    if (doWrite) begin
      mem[wrPtr] <= wrFlit;
    end
  end

  // Pointers and fill count
  always_ff @(posedge clk) begin
    if (rst) begin
      wrPtr <= '0;
      rdPtr <= '0;
      count <= '0;
    end else begin
      if (doWrite) begin
        // Wrap at the last entry
        wrPtr <= (wrPtr == PtrW'(`FIFO_DEPTH - 1)) ? '0 : wrPtr + 1'b1;
      end
      if (doRead) begin
        rdPtr <= (rdPtr == PtrW'(`FIFO_DEPTH - 1)) ? '0 : rdPtr + 1'b1;
      end
      // Simultaneous read and write keeps the count
      case ({doWrite, doRead})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

endmodule

//--- src/nocPkg.sv
// NoC router package with flit, address, routing and arbiter types
`include "nocSettings.svh"

package nocPkg;

  // One flit on a link
  typedef logic [`FLIT_W-1:0] flit_t;

  // Flit id field, one-hot header/payload/tail
  typedef logic [`ID_HI-`ID_LO:0] flitId_t;

  // Mesh address, x in [1:0] and y in [3:2]
  typedef logic [`DST_HI-`DST_LO:0] addr_t;

  // Routing bits, Rne at bit 0 up to Rsw at bit 7
  typedef logic [7:0] routeBits_t;

  // Connectivity bits Cn, Ce, Cw, Cs from bit 0
  typedef logic [3:0] connBits_t;

  // One bit per port, indexed with the port macros
  typedef logic [`NUM_PORTS-1:0] portVec_t;

  // Output arbiter FSM
  typedef enum logic {
    arbIdle,
    arbLocked
  } arbState_t;

endpackage

//--- src/nocSettings.svh
// NoC router settings with flit id codes, flit field positions and sizes
`ifndef NOC_SETTINGS_SVH
`define NOC_SETTINGS_SVH

// Flit id codes, one-hot
`define HEADER 3'b001
`define PAYLOAD 3'b010
`define TAIL 3'b100

// Flit layout
`define FLIT_W 32
`define ID_HI 31
`define ID_LO 29
`define DST_HI 28
`define DST_LO 25

// Sizes
`define FIFO_DEPTH 4
`define NUM_PORTS 5

// Port indices into every port vector
`define PORT_N 0
`define PORT_E 1
`define PORT_W 2
`define PORT_S 3
`define PORT_L 4

`endif
